/* prf_cfg_pkg.sv */
`default_nettype none

package prf_cfg_pkg;

    // ------------------------------------------------------------------------
    // register file geometry
    // ------------------------------------------------------------------------

    // physical registers
    localparam int PR_COUNT = 64;
    localparam int LOG_PR_COUNT = 6;

    // banks, steered by low pr bits
    localparam int BANK_COUNT = 4;
    localparam int LOG_BANK_COUNT = 2;

    // rows within one bank
    localparam int ROWS_PER_BANK = PR_COUNT / BANK_COUNT;
    localparam int LOG_ROWS = LOG_PR_COUNT - LOG_BANK_COUNT;

    // requesters
    localparam int RR_COUNT = 4;
    localparam int WR_COUNT = 2;

    // rob index and data width
    localparam int LOG_ROB_ENTRIES = 6;
    localparam int DATA_WIDTH = 32;

endpackage

`default_nettype wire

/* prf_types_pkg.sv */
`default_nettype none

package prf_types_pkg;

    // ------------------------------------------------------------------------
    // scalar types
    // ------------------------------------------------------------------------

    // row within one bank
    typedef logic [prf_cfg_pkg::LOG_ROWS-1:0] row_t;

    // bank number
    typedef logic [prf_cfg_pkg::LOG_BANK_COUNT-1:0] bank_t;

    // reorder buffer index
    typedef logic [prf_cfg_pkg::LOG_ROB_ENTRIES-1:0] rob_index_t;

    // register value
    typedef logic [prf_cfg_pkg::DATA_WIDTH-1:0] word_t;

    // ------------------------------------------------------------------------
    // physical register number
    // ------------------------------------------------------------------------

    // upper bits pick the row, low bits pick the bank
    typedef struct packed {
        row_t  row;
        bank_t bank;
    } pr_split_t;

    typedef union packed {
        logic [prf_cfg_pkg::LOG_PR_COUNT-1:0] flat;
        pr_split_t                            split;
    } pr_t;

endpackage

`default_nettype wire

/* prf_bank_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module prf_bank_arbiter #(
    parameter int N = 4
) (
    input  wire logic         CLK,
    input  wire logic         nRST,
    input  wire logic [N-1:0] req,
    output logic [N-1:0]      grant
);

    // requesters strictly below the last winner
    logic [N-1:0] mask;
    logic [N-1:0] next_mask;
    logic [N-1:0] masked_req;

    // highest set bit wins, result one-hot or zero
    function automatic logic [N-1:0] pick_high(input logic [N-1:0] vec);
        logic [N-1:0] onehot;
        onehot = '0;
        // walk up so the msb has the last say
        for (int i = 0; i < N; i++) begin
            if (vec[i]) begin
                onehot = '0;
                onehot[i] = 1'b1;
            end
        end
        return onehot;
    endfunction

    assign masked_req = req & mask;

    // fall back to the full vector once the mask runs dry
    assign grant = (|masked_req) ? pick_high(masked_req) : pick_high(req);

    always_comb begin
        next_mask = '0;
        // thermometer below the winner, clear when nothing won
        for (int i = N - 2; i >= 0; i--) begin
            next_mask[i] = grant[i+1] | next_mask[i+1];
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            mask <= '0;
        end else begin
            mask <= next_mask;
        end
    end

endmodule

`default_nettype wire

/* prf_bank_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module prf_bank_ram (
    input  wire logic CLK,
    input  wire logic nRST,

    // async read through the registered row
    input  wire prf_types_pkg::row_t read_row,
    output prf_types_pkg::word_t     read_data,

    // write from the bus stage
    input  wire logic                 write_en,
    input  wire prf_types_pkg::row_t  write_row,
    input  wire prf_types_pkg::word_t write_data
);

    // distributed storage, one word per row
    prf_types_pkg::word_t mem [prf_cfg_pkg::ROWS_PER_BANK];

    assign read_data = mem[read_row];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            // all registers start at zero
            for (int i = 0; i < prf_cfg_pkg::ROWS_PER_BANK; i++) begin
                mem[i] <= '0;
            end
        end else if (write_en) begin
            mem[write_row] <= write_data;
        end
    end

endmodule

`default_nettype wire

/* prf_wb_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module prf_wb_decode (
    input  wire logic CLK,
    input  wire logic nRST,

    // new writebacks by writer
    input  wire logic [prf_cfg_pkg::WR_COUNT-1:0]                         wb_valid,
    input  wire prf_types_pkg::word_t [prf_cfg_pkg::WR_COUNT-1:0]         wb_data,
    input  wire prf_types_pkg::pr_t [prf_cfg_pkg::WR_COUNT-1:0]           wb_pr,
    input  wire prf_types_pkg::rob_index_t [prf_cfg_pkg::WR_COUNT-1:0]    wb_rob_index,

    // arbiter handshake per bank
    input  wire logic [prf_cfg_pkg::BANK_COUNT-1:0][prf_cfg_pkg::WR_COUNT-1:0] grant_by_bank,
    output logic [prf_cfg_pkg::BANK_COUNT-1:0][prf_cfg_pkg::WR_COUNT-1:0]      req_by_bank,

    // merged fields toward the result stage
    output prf_types_pkg::word_t [prf_cfg_pkg::WR_COUNT-1:0]      sel_data,
    output prf_types_pkg::pr_t [prf_cfg_pkg::WR_COUNT-1:0]        sel_pr,
    output prf_types_pkg::rob_index_t [prf_cfg_pkg::WR_COUNT-1:0] sel_rob_index,

    // backpressure by writer
    output logic [prf_cfg_pkg::WR_COUNT-1:0] wb_ready
);

    // held writebacks that lost arbitration
    logic [prf_cfg_pkg::WR_COUNT-1:0]                      held_valid;
    prf_types_pkg::word_t [prf_cfg_pkg::WR_COUNT-1:0]      held_data;
    prf_types_pkg::pr_t [prf_cfg_pkg::WR_COUNT-1:0]        held_pr;
    prf_types_pkg::rob_index_t [prf_cfg_pkg::WR_COUNT-1:0] held_rob_index;

    logic [prf_cfg_pkg::WR_COUNT-1:0] sel_valid;
    logic [prf_cfg_pkg::WR_COUNT-1:0] ack;

    // ------------------------------------------------------------------------
    // merge and steer
    // ------------------------------------------------------------------------

    always_comb begin
        req_by_bank = '0;
        ack = '0;
        for (int w = 0; w < prf_cfg_pkg::WR_COUNT; w++) begin
            // held entry wins over the new one
            sel_valid[w] = held_valid[w] | wb_valid[w];
            sel_data[w] = held_valid[w] ? held_data[w] : wb_data[w];
            sel_pr[w] = held_valid[w] ? held_pr[w] : wb_pr[w];
            sel_rob_index[w] = held_valid[w] ? held_rob_index[w] : wb_rob_index[w];
            // one bank bit per writer
            req_by_bank[sel_pr[w].split.bank][w] = sel_valid[w];
        end
        // collapse grants over banks
        for (int b = 0; b < prf_cfg_pkg::BANK_COUNT; b++) begin
            ack |= grant_by_bank[b];
        end
    end

    // stall only while a new writeback collides with a held one
    assign wb_ready = ~(wb_valid & held_valid);

    // ------------------------------------------------------------------------
    // held state
    // ------------------------------------------------------------------------

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            held_valid <= '0;
        end else begin
            held_valid <= sel_valid & ~ack;
        end
    end

    // payload follows the merged choice every cycle
    always_ff @(posedge CLK) begin
        held_data <= sel_data;
        held_pr <= sel_pr;
        held_rob_index <= sel_rob_index;
    end

endmodule

`default_nettype wire

/* prf_rd_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module prf_rd_decode (
    input  wire logic CLK,
    input  wire logic nRST,

    // read requests by reader
    input  wire logic [prf_cfg_pkg::RR_COUNT-1:0]               rd_req_valid,
    input  wire prf_types_pkg::pr_t [prf_cfg_pkg::RR_COUNT-1:0] rd_req_pr,

    // arbiter handshake per bank
    input  wire logic [prf_cfg_pkg::BANK_COUNT-1:0][prf_cfg_pkg::RR_COUNT-1:0] grant_by_bank,
    output logic [prf_cfg_pkg::BANK_COUNT-1:0][prf_cfg_pkg::RR_COUNT-1:0]      req_by_bank,

    output logic [prf_cfg_pkg::RR_COUNT-1:0] rd_ack,

    // registered ram index per bank
    output prf_types_pkg::row_t [prf_cfg_pkg::BANK_COUNT-1:0] read_row_by_bank
);

    logic [prf_cfg_pkg::RR_COUNT-1:0]               held_valid;
    prf_types_pkg::pr_t [prf_cfg_pkg::RR_COUNT-1:0] held_pr;

    logic [prf_cfg_pkg::RR_COUNT-1:0]                    sel_valid;
    prf_types_pkg::pr_t [prf_cfg_pkg::RR_COUNT-1:0]      sel_pr;
    prf_types_pkg::row_t [prf_cfg_pkg::BANK_COUNT-1:0]   next_row_by_bank;

    // ------------------------------------------------------------------------
    // merge, steer and ack
    // ------------------------------------------------------------------------

    always_comb begin
        req_by_bank = '0;
        rd_ack = '0;
        for (int r = 0; r < prf_cfg_pkg::RR_COUNT; r++) begin
            // held request shadows new input
            sel_valid[r] = held_valid[r] | rd_req_valid[r];
            sel_pr[r] = held_valid[r] ? held_pr[r] : rd_req_pr[r];
            req_by_bank[sel_pr[r].split.bank][r] = sel_valid[r];
        end
        for (int b = 0; b < prf_cfg_pkg::BANK_COUNT; b++) begin
            rd_ack |= grant_by_bank[b];
        end
    end

    // one-hot mux of the granted row per bank
    always_comb begin
        for (int b = 0; b < prf_cfg_pkg::BANK_COUNT; b++) begin
            next_row_by_bank[b] = '0;
            for (int r = 0; r < prf_cfg_pkg::RR_COUNT; r++) begin
                next_row_by_bank[b] |=
                    sel_pr[r].split.row & {prf_cfg_pkg::LOG_ROWS{grant_by_bank[b][r]}};
            end
        end
    end

    // ------------------------------------------------------------------------
    // state
    // ------------------------------------------------------------------------

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            held_valid <= '0;
            read_row_by_bank <= '0;
        end else begin
            held_valid <= sel_valid & ~rd_ack;
            // ram reads this index next cycle
            read_row_by_bank <= next_row_by_bank;
        end
    end

    always_ff @(posedge CLK) begin
        held_pr <= sel_pr;
    end

endmodule

`default_nettype wire

/* prf_wb_result.sv */
`timescale 1ns/100ps
`default_nettype none

module prf_wb_result (
    input  wire logic CLK,
    input  wire logic nRST,

    // grants and merged writer fields
    input  wire logic [prf_cfg_pkg::BANK_COUNT-1:0][prf_cfg_pkg::WR_COUNT-1:0] grant_by_bank,
    input  wire prf_types_pkg::word_t [prf_cfg_pkg::WR_COUNT-1:0]      sel_data,
    input  wire prf_types_pkg::pr_t [prf_cfg_pkg::WR_COUNT-1:0]        sel_pr,
    input  wire prf_types_pkg::rob_index_t [prf_cfg_pkg::WR_COUNT-1:0] sel_rob_index,

    // writeback bus per bank
    output logic [prf_cfg_pkg::BANK_COUNT-1:0]                           bus_valid,
    output prf_types_pkg::word_t [prf_cfg_pkg::BANK_COUNT-1:0]           bus_data,
    output prf_types_pkg::row_t [prf_cfg_pkg::BANK_COUNT-1:0]            bus_row,
    output prf_types_pkg::rob_index_t [prf_cfg_pkg::BANK_COUNT-1:0]      bus_rob_index,

    // forward data one cycle behind the bus
    output prf_types_pkg::word_t [prf_cfg_pkg::BANK_COUNT-1:0] fwd_data
);

    logic [prf_cfg_pkg::BANK_COUNT-1:0]                      next_valid;
    prf_types_pkg::word_t [prf_cfg_pkg::BANK_COUNT-1:0]      next_data;
    prf_types_pkg::row_t [prf_cfg_pkg::BANK_COUNT-1:0]       next_row;
    prf_types_pkg::rob_index_t [prf_cfg_pkg::BANK_COUNT-1:0] next_rob_index;

    // ------------------------------------------------------------------------
    // one-hot select per bank
    // ------------------------------------------------------------------------

    always_comb begin
        for (int b = 0; b < prf_cfg_pkg::BANK_COUNT; b++) begin
            // any grant means this bank writes
            next_valid[b] = |grant_by_bank[b];
            next_data[b] = '0;
            next_row[b] = '0;
            next_rob_index[b] = '0;
            // and with grant, or over writers
            for (int w = 0; w < prf_cfg_pkg::WR_COUNT; w++) begin
                next_data[b] |=
                    sel_data[w] & {prf_cfg_pkg::DATA_WIDTH{grant_by_bank[b][w]}};
                next_row[b] |=
                    sel_pr[w].split.row & {prf_cfg_pkg::LOG_ROWS{grant_by_bank[b][w]}};
                next_rob_index[b] |=
                    sel_rob_index[w] & {prf_cfg_pkg::LOG_ROB_ENTRIES{grant_by_bank[b][w]}};
            end
        end
    end

    // ------------------------------------------------------------------------
    // bus and forward registers
    // ------------------------------------------------------------------------

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            bus_valid <= '0;
            bus_data <= '0;
            bus_row <= '0;
            bus_rob_index <= '0;
            fwd_data <= '0;
        end else begin
            bus_valid <= next_valid;
            bus_data <= next_data;
            bus_row <= next_row;
            bus_rob_index <= next_rob_index;
            // consumers pick the value up here
            fwd_data <= bus_data;
        end
    end

endmodule

`default_nettype wire

/* prf.sv */
`timescale 1ns/100ps
`default_nettype none

module prf (
    input  wire logic CLK,
    input  wire logic nRST,

    // read requests by reader
    input  wire logic [prf_cfg_pkg::RR_COUNT-1:0]               rd_req_valid,
    input  wire prf_types_pkg::pr_t [prf_cfg_pkg::RR_COUNT-1:0] rd_req_pr,
    output logic [prf_cfg_pkg::RR_COUNT-1:0]                    rd_ack,
    output prf_types_pkg::word_t [prf_cfg_pkg::BANK_COUNT-1:0]  rd_data,

    // writebacks by writer
    input  wire logic [prf_cfg_pkg::WR_COUNT-1:0]                         wb_valid,
    input  wire prf_types_pkg::word_t [prf_cfg_pkg::WR_COUNT-1:0]         wb_data,
    input  wire prf_types_pkg::pr_t [prf_cfg_pkg::WR_COUNT-1:0]           wb_pr,
    input  wire prf_types_pkg::rob_index_t [prf_cfg_pkg::WR_COUNT-1:0]    wb_rob_index,
    output logic [prf_cfg_pkg::WR_COUNT-1:0]                              wb_ready,

    // writeback bus by bank
    output logic [prf_cfg_pkg::BANK_COUNT-1:0]                      bus_valid,
    output prf_types_pkg::word_t [prf_cfg_pkg::BANK_COUNT-1:0]      bus_data,
    output prf_types_pkg::row_t [prf_cfg_pkg::BANK_COUNT-1:0]       bus_row,
    output prf_types_pkg::rob_index_t [prf_cfg_pkg::BANK_COUNT-1:0] bus_rob_index,

    output prf_types_pkg::word_t [prf_cfg_pkg::BANK_COUNT-1:0] fwd_data
);

    // read path
    logic [prf_cfg_pkg::BANK_COUNT-1:0][prf_cfg_pkg::RR_COUNT-1:0] rd_req_by_bank;
    logic [prf_cfg_pkg::BANK_COUNT-1:0][prf_cfg_pkg::RR_COUNT-1:0] rd_grant_by_bank;
    prf_types_pkg::row_t [prf_cfg_pkg::BANK_COUNT-1:0]             read_row_by_bank;

    // writeback path
    logic [prf_cfg_pkg::BANK_COUNT-1:0][prf_cfg_pkg::WR_COUNT-1:0] wb_req_by_bank;
    logic [prf_cfg_pkg::BANK_COUNT-1:0][prf_cfg_pkg::WR_COUNT-1:0] wb_grant_by_bank;
    prf_types_pkg::word_t [prf_cfg_pkg::WR_COUNT-1:0]              wb_sel_data;
    prf_types_pkg::pr_t [prf_cfg_pkg::WR_COUNT-1:0]                wb_sel_pr;
    prf_types_pkg::rob_index_t [prf_cfg_pkg::WR_COUNT-1:0]         wb_sel_rob_index;

    // ------------------------------------------------------------------------
    // decode
    // ------------------------------------------------------------------------

    prf_wb_decode wb_decode_inst (
        .CLK(CLK), .nRST(nRST),
        .wb_valid(wb_valid), .wb_data(wb_data), .wb_pr(wb_pr), .wb_rob_index(wb_rob_index),
        .grant_by_bank(wb_grant_by_bank), .req_by_bank(wb_req_by_bank),
        .sel_data(wb_sel_data), .sel_pr(wb_sel_pr), .sel_rob_index(wb_sel_rob_index),
        .wb_ready(wb_ready)
    );

    prf_rd_decode rd_decode_inst (
        .CLK(CLK), .nRST(nRST),
        .rd_req_valid(rd_req_valid), .rd_req_pr(rd_req_pr),
        .grant_by_bank(rd_grant_by_bank), .req_by_bank(rd_req_by_bank),
        .rd_ack(rd_ack), .read_row_by_bank(read_row_by_bank)
    );

    // ------------------------------------------------------------------------
    // per bank arbiters and storage
    // ------------------------------------------------------------------------

    for (genvar b = 0; b < prf_cfg_pkg::BANK_COUNT; b++) begin : g_bank
        prf_bank_arbiter #(.N(prf_cfg_pkg::RR_COUNT)) rd_arb_inst (
            .CLK(CLK), .nRST(nRST),
            .req(rd_req_by_bank[b]), .grant(rd_grant_by_bank[b])
        );

        prf_bank_arbiter #(.N(prf_cfg_pkg::WR_COUNT)) wb_arb_inst (
            .CLK(CLK), .nRST(nRST),
            .req(wb_req_by_bank[b]), .grant(wb_grant_by_bank[b])
        );

        // written straight from the bus registers
        prf_bank_ram ram_inst (
            .CLK(CLK), .nRST(nRST),
            .read_row(read_row_by_bank[b]), .read_data(rd_data[b]),
            .write_en(bus_valid[b]), .write_row(bus_row[b]), .write_data(bus_data[b])
        );
    end

    // ------------------------------------------------------------------------
    // result
    // ------------------------------------------------------------------------

    prf_wb_result wb_result_inst (
        .CLK(CLK), .nRST(nRST),
        .grant_by_bank(wb_grant_by_bank),
        .sel_data(wb_sel_data), .sel_pr(wb_sel_pr), .sel_rob_index(wb_sel_rob_index),
        .bus_valid(bus_valid), .bus_data(bus_data), .bus_row(bus_row),
        .bus_rob_index(bus_rob_index), .fwd_data(fwd_data)
    );

endmodule

`default_nettype wire

/* prf_assert.sv */
`timescale 1ns/100ps
`default_nettype none

module prf_assert (
    input wire logic                                               CLK,
    input wire logic                                               nRST,
    input wire logic [prf_cfg_pkg::RR_COUNT-1:0]                   rd_ack,
    input wire logic [prf_cfg_pkg::WR_COUNT-1:0]                   wb_valid,
    input wire logic [prf_cfg_pkg::WR_COUNT-1:0]                   wb_ready,
    input wire logic [prf_cfg_pkg::BANK_COUNT-1:0]                 bus_valid,
    input wire prf_types_pkg::word_t [prf_cfg_pkg::BANK_COUNT-1:0] bus_data,
    input wire prf_types_pkg::word_t [prf_cfg_pkg::BANK_COUNT-1:0] fwd_data
);

    // a held writer always wins the next round, so no stall lasts two cycles
    stall_one_cycle: assert property (
        @(posedge CLK) disable iff (!nRST) ((~wb_ready & ~$past(wb_ready)) == '0)
    ) else $error("wb_ready low in two consecutive cycles");

    // ------------------------------------------------------------------------
    // forward path trails the bus by one edge
    // ------------------------------------------------------------------------
    fwd_follows_bus: assert property (
        @(posedge CLK) disable iff (!nRST) (fwd_data == $past(bus_data))
    ) else $error("fwd_data differs from bus_data of the previous cycle");

    // handshake levels never unknown
    levels_known: assert property (
        @(posedge CLK) disable iff (!nRST) !$isunknown({rd_ack, wb_ready, bus_valid})
    ) else $error("unknown value on rd_ack, wb_ready or bus_valid");

endmodule

`default_nettype wire

/* prf_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module prf_tb;

    localparam int TIMEOUT = 64;
    localparam int SEED = 76;

    logic CLK;
    logic nRST;

    // read side
    logic [prf_cfg_pkg::RR_COUNT-1:0]                        rd_req_valid;
    prf_types_pkg::pr_t [prf_cfg_pkg::RR_COUNT-1:0]          rd_req_pr;
    logic [prf_cfg_pkg::RR_COUNT-1:0]                        rd_ack;
    prf_types_pkg::word_t [prf_cfg_pkg::BANK_COUNT-1:0]      rd_data;

    // writeback side
    logic [prf_cfg_pkg::WR_COUNT-1:0]                        wb_valid;
    prf_types_pkg::word_t [prf_cfg_pkg::WR_COUNT-1:0]        wb_data;
    prf_types_pkg::pr_t [prf_cfg_pkg::WR_COUNT-1:0]          wb_pr;
    prf_types_pkg::rob_index_t [prf_cfg_pkg::WR_COUNT-1:0]   wb_rob_index;
    logic [prf_cfg_pkg::WR_COUNT-1:0]                        wb_ready;

    // bus and forward outputs
    logic [prf_cfg_pkg::BANK_COUNT-1:0]                      bus_valid;
    prf_types_pkg::word_t [prf_cfg_pkg::BANK_COUNT-1:0]      bus_data;
    prf_types_pkg::row_t [prf_cfg_pkg::BANK_COUNT-1:0]       bus_row;
    prf_types_pkg::rob_index_t [prf_cfg_pkg::BANK_COUNT-1:0] bus_rob_index;
    prf_types_pkg::word_t [prf_cfg_pkg::BANK_COUNT-1:0]      fwd_data;

    // reference copy of every register
    prf_types_pkg::word_t model [prf_cfg_pkg::PR_COUNT];

    int    errors;
    int    checks;
    int    test_errors;
    int    waited;
    string test_name;

    prf prf_inst (.*);

    bind prf prf_assert prf_assert_inst (.*);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // ------------------------------------------------------------------------
    // compare and report
    // ------------------------------------------------------------------------

    task automatic compare_word(input string what, input prf_types_pkg::word_t exp,
                                input prf_types_pkg::word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic compare_row(input string what, input prf_types_pkg::row_t exp,
                               input prf_types_pkg::row_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic compare_rob(input string what, input prf_types_pkg::rob_index_t exp,
                               input prf_types_pkg::rob_index_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic compare_bit(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("%s: no %s within %0d cycles", test_name, what, TIMEOUT);
        $display("Test failed");
        $finish;
    endtask

    task automatic report_test();
        $display("test %s finished with %0d errors", test_name, errors - test_errors);
        test_errors = errors;
    endtask

    // ------------------------------------------------------------------------
    // bus level tasks
    // ------------------------------------------------------------------------

    // one writeback, checked on its bank's bus; bus_wait counts extra cycles
    task automatic write_reg(input int w, input int pr, input prf_types_pkg::word_t data,
                             input prf_types_pkg::rob_index_t rob, output int bus_wait);
        int n;
        int bank;
        logic accepted;
        bank = pr % prf_cfg_pkg::BANK_COUNT;
        @(negedge CLK);
        wb_valid[w] = 1'b1;
        wb_pr[w].flat = pr[prf_cfg_pkg::LOG_PR_COUNT-1:0];
        wb_data[w] = data;
        wb_rob_index[w] = rob;
        accepted = 1'b0;
        n = 0;
        // inputs stay put until ready was seen high
        while (!accepted) begin
            if (n == TIMEOUT) stop_on_timeout("wb_ready");
            // mid low phase, everything settled
            #2;
            accepted = wb_ready[w];
            @(negedge CLK);
            n++;
        end
        wb_valid[w] = 1'b0;
        bus_wait = 0;
        #2;
        while (!bus_valid[bank]) begin
            if (bus_wait == TIMEOUT) stop_on_timeout("bus_valid");
            @(negedge CLK);
            #2;
            bus_wait++;
        end
        compare_row("bus_row", prf_types_pkg::row_t'(pr / prf_cfg_pkg::BANK_COUNT),
                    bus_row[bank]);
        compare_word("bus_data", data, bus_data[bank]);
        compare_rob("bus_rob_index", rob, bus_rob_index[bank]);
        model[pr] = data;
    endtask

    // one read, data checked one cycle after the ack
    task automatic read_reg(input int r, input int pr, output int wait_cycles);
        int bank;
        logic acked;
        bank = pr % prf_cfg_pkg::BANK_COUNT;
        @(negedge CLK);
        rd_req_valid[r] = 1'b1;
        rd_req_pr[r].flat = pr[prf_cfg_pkg::LOG_PR_COUNT-1:0];
        acked = 1'b0;
        wait_cycles = 0;
        while (!acked) begin
            if (wait_cycles == TIMEOUT) stop_on_timeout("rd_ack");
            #2;
            acked = rd_ack[r];
            // request shown once, the DUT holds it after that
            @(negedge CLK);
            rd_req_valid[r] = 1'b0;
            if (!acked) wait_cycles++;
        end
        #2;
        compare_word("rd_data", model[pr], rd_data[bank]);
    endtask

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------

    task automatic test_reset_state();
        test_name = "reset_state";
        @(negedge CLK);
        #2;
        for (int b = 0; b < prf_cfg_pkg::BANK_COUNT; b++) begin
            compare_bit("bus_valid", 1'b0, bus_valid[b]);
            compare_word("fwd_data", '0, fwd_data[b]);
        end
        for (int r = 0; r < prf_cfg_pkg::RR_COUNT; r++) begin
            compare_bit("rd_ack", 1'b0, rd_ack[r]);
        end
        for (int w = 0; w < prf_cfg_pkg::WR_COUNT; w++) begin
            compare_bit("wb_ready", 1'b1, wb_ready[w]);
        end
        // one register per bank reads zero
        for (int b = 0; b < prf_cfg_pkg::BANK_COUNT; b++) begin
            read_reg(b % prf_cfg_pkg::RR_COUNT, 20 + b, waited);
        end
        report_test();
    endtask

    task automatic test_single_write();
        prf_types_pkg::word_t data;
        test_name = "single_write";
        data = $urandom;
        // register 13 is bank 1, row 3
        write_reg(0, 13, data, 6'd5, waited);
        compare_bit("bus in next cycle", 1'b1, waited == 0);
        @(negedge CLK);
        #2;
        compare_word("fwd_data", data, fwd_data[1]);
        read_reg(2, 13, waited);
        compare_bit("ack in request cycle", 1'b1, waited == 0);
        report_test();
    endtask

    task automatic test_bank_conflict();
        prf_types_pkg::word_t d0;
        prf_types_pkg::word_t d1;
        test_name = "bank_conflict";
        d0 = $urandom;
        d1 = $urandom;
        // both writers into bank 0, rows 1 and 2
        @(negedge CLK);
        wb_valid = '1;
        wb_pr[0].flat = 6'd4;
        wb_pr[1].flat = 6'd8;
        wb_data[0] = d0;
        wb_data[1] = d1;
        wb_rob_index[0] = 6'd10;
        wb_rob_index[1] = 6'd11;
        @(negedge CLK);
        wb_valid[1] = 1'b0;
        #2;
        // higher writer first, lower one stalls
        compare_bit("wb_ready[0]", 1'b0, wb_ready[0]);
        compare_bit("bus_valid", 1'b1, bus_valid[0]);
        compare_row("bus_row", 4'd2, bus_row[0]);
        compare_word("bus_data", d1, bus_data[0]);
        compare_rob("bus_rob_index", 6'd11, bus_rob_index[0]);
        @(negedge CLK);
        wb_valid[0] = 1'b0;
        #2;
        compare_bit("bus_valid", 1'b1, bus_valid[0]);
        compare_row("bus_row", 4'd1, bus_row[0]);
        compare_word("bus_data", d0, bus_data[0]);
        compare_rob("bus_rob_index", 6'd10, bus_rob_index[0]);
        model[4] = d0;
        model[8] = d1;
        read_reg(0, 4, waited);
        read_reg(1, 8, waited);
        report_test();
    endtask

    task automatic test_two_banks();
        prf_types_pkg::word_t d0;
        prf_types_pkg::word_t d1;
        test_name = "two_banks";
        d0 = $urandom;
        d1 = $urandom;
        // 17 is bank 1 row 4, 30 is bank 2 row 7
        @(negedge CLK);
        wb_valid = '1;
        wb_pr[0].flat = 6'd17;
        wb_pr[1].flat = 6'd30;
        wb_data[0] = d0;
        wb_data[1] = d1;
        wb_rob_index[0] = 6'd20;
        wb_rob_index[1] = 6'd21;
        #2;
        compare_bit("wb_ready[0]", 1'b1, wb_ready[0]);
        compare_bit("wb_ready[1]", 1'b1, wb_ready[1]);
        @(negedge CLK);
        wb_valid = '0;
        #2;
        compare_bit("bus_valid[1]", 1'b1, bus_valid[1]);
        compare_bit("bus_valid[2]", 1'b1, bus_valid[2]);
        compare_row("bus_row[1]", 4'd4, bus_row[1]);
        compare_row("bus_row[2]", 4'd7, bus_row[2]);
        compare_word("bus_data[1]", d0, bus_data[1]);
        compare_word("bus_data[2]", d1, bus_data[2]);
        model[17] = d0;
        model[30] = d1;
        read_reg(0, 17, waited);
        read_reg(1, 30, waited);
        report_test();
    endtask

    task automatic test_read_contention();
        test_name = "read_contention";
        // registers 3, 7, 11, 15 all sit in bank 3
        for (int r = 0; r < prf_cfg_pkg::RR_COUNT; r++) begin
            write_reg(r % prf_cfg_pkg::WR_COUNT, 4 * r + 3, $urandom,
                      prf_types_pkg::rob_index_t'(r), waited);
        end
        @(negedge CLK);
        for (int r = 0; r < prf_cfg_pkg::RR_COUNT; r++) begin
            rd_req_valid[r] = 1'b1;
            rd_req_pr[r].flat = 6'(4 * r + 3);
        end
        for (int c = 0; c < prf_cfg_pkg::RR_COUNT; c++) begin
            #2;
            // grant walks down one reader per cycle
            for (int r = 0; r < prf_cfg_pkg::RR_COUNT; r++) begin
                compare_bit("rd_ack", r == prf_cfg_pkg::RR_COUNT - 1 - c, rd_ack[r]);
            end
            if (c > 0) compare_word("rd_data", model[4 * (4 - c) + 3], rd_data[3]);
            @(negedge CLK);
            rd_req_valid = '0;
        end
        #2;
        compare_word("rd_data", model[3], rd_data[3]);
        for (int r = 0; r < prf_cfg_pkg::RR_COUNT; r++) begin
            compare_bit("rd_ack idle", 1'b0, rd_ack[r]);
        end
        report_test();
    endtask

    task automatic test_random_sweep();
        int order [prf_cfg_pkg::PR_COUNT];
        int pick;
        int tmp;
        test_name = "random_sweep";
        for (int p = 0; p < prf_cfg_pkg::PR_COUNT; p++) begin
            write_reg(p % prf_cfg_pkg::WR_COUNT, p, $urandom,
                      prf_types_pkg::rob_index_t'(p), waited);
            order[p] = p;
        end
        // shuffle of the read order
        for (int p = prf_cfg_pkg::PR_COUNT - 1; p > 0; p--) begin
            pick = int'($urandom % (p + 1));
            tmp = order[p];
            order[p] = order[pick];
            order[pick] = tmp;
        end
        for (int p = 0; p < prf_cfg_pkg::PR_COUNT; p++) begin
            read_reg(p % prf_cfg_pkg::RR_COUNT, order[p], waited);
        end
        report_test();
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------

    initial begin
        errors = 0;
        checks = 0;
        test_errors = 0;
        nRST = 1'b0;
        rd_req_valid = '0;
        rd_req_pr = '0;
        wb_valid = '0;
        wb_data = '0;
        wb_pr = '0;
        wb_rob_index = '0;
        void'($urandom(SEED));
        for (int p = 0; p < prf_cfg_pkg::PR_COUNT; p++) begin
            model[p] = '0;
        end
        repeat (16) @(negedge CLK);
        nRST = 1'b1;
        test_reset_state();
        test_single_write();
        test_bank_conflict();
        test_two_banks();
        test_read_contention();
        test_random_sweep();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
prf_cfg_pkg.sv
prf_types_pkg.sv
prf_bank_arbiter.sv
prf_bank_ram.sv
prf_wb_decode.sv
prf_rd_decode.sv
prf_wb_result.sv
prf.sv
prf_assert.sv
prf_tb.sv

/* run.sh */
#!/bin/sh
# build and run the register file testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module prf_tb -f all.f -o prf_sim
./obj_dir/prf_sim | tee sim.log

# verdict comes from the log
if grep -q "^Test passed$" sim.log; then
    echo "simulation ok"
else
    echo "simulation reported failure"
    exit 1
fi
